// File: build.f
+incdir+design
+incdir+verif
design/cpu_isa_pkg.sv
design/cpu_ctrl_pkg.sv
design/cpu_ctrl_if.sv
design/alu.sv
design/stack.sv
design/insn_decoder.sv
design/cdtimer.sv
design/cpu.sv
verif/tb_cpu.sv

// File: run.sh
#!/bin/sh
# Build and run the CPU testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f build.f --top-module tb_cpu -o tb_cpu
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator compile failed"
  exit $status
fi

./obj_dir/tb_cpu
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed"
  exit $status
fi
exit 0

// File: verif/cpu_model.svh
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

localparam int STEP_LIMIT = 4000;
localparam int PROG_ITEMS = 60;
// ALU function codes of the stack operations
localparam logic [5:0] ALU_CODES [18] = '{
  6'h00, 6'h01, 6'h02, 6'h04, 6'h0f, 6'h10, 6'h11, 6'h12, 6'h13,
  6'h14, 6'h15, 6'h16, 6'h20, 6'h21, 6'h22, 6'h28, 6'h29, 6'h2a
};

// Program image and the model's own memory copy
logic [7:0]  image [4096];
logic [7:0]  mmem [4096];
// Model registers
logic [15:0] ds [8];
logic [15:0] cs [8];
logic [15:0] m_ip;
logic [15:0] m_fp;
// Expected write sequence
logic [15:0] exp_addr [$];
logic [15:0] exp_data [$];
bit          exp_byt [$];
// ALU function of each stack operation and the cycle of its EXEC phase
int          alu_cyc [$];
logic [5:0]  alu_code [$];
int          model_cycles;
bit          model_done;
int          pc;

task automatic emit(logic [15:0] w);
  // Little endian, odd byte is the high lane
  image[pc] = w[7:0];
  image[pc+1] = w[15:8];
  pc += 2;
endtask

function automatic logic [15:0] rand_addr(bit byte_ok);
  logic [15:0] a;
  a = 16'h0200 | 16'($urandom % 256);
  if (!byte_ok) a[0] = 1'b0;
  return a;
endfunction

task automatic gen_program();
  int kind;
  int v;
  logic [15:0] a;
  for (int i = 0; i < 4096; i++) image[i] = 8'((i >> 4) ^ (i * 37));
  pc = `RESET_IP;
  // Timer: load 2, read right away through a compare, then expired reads
  emit(16'h8002);
  emit(16'h2003);
  emit(16'h8003);
  emit(16'h2002);
  // LT with pop, result is 1 for any count up to 2
  emit(16'h7068);
  emit(16'h2105);
  emit(16'h2002);
  emit(16'h2101);
  // Other built-in address reads zero
  emit(16'h2040);
  emit(16'h2103);
  for (int i = 0; i < PROG_ITEMS; i++) begin
    kind = $urandom % 8;
    case (kind)
      0: emit(16'h8000 | 16'($urandom % 32768));
      1: begin
        v = $urandom % 3;
        a = (v == 1) ? 16'h0080 : ((v == 2) ? 16'h0040 : 16'h0000);
        emit(16'h7000 | a | 16'(ALU_CODES[$urandom % 18]));
      end
      2: emit(16'h2001 | 16'(16'h0100 + ($urandom % 127) * 2));
      3: begin
        // JMP, JZ or JNZ over one word
        v = $urandom % 3;
        emit((v == 0) ? 16'h0002 : ((v == 1) ? 16'h1002 : 16'h1003));
        emit(16'h8000 | 16'($urandom % 32768));
      end
      4: begin
        // CALL into a frame, jump around the subroutine body on return
        emit(16'h0003);
        emit(16'h000c);
        emit(16'h7803);
        emit(16'h4000 | 16'(16'h0100 + ($urandom % 64) * 2));
        v = ($urandom % 64) * 2;
        emit(16'h2401 | 16'(v));
        emit(16'h2400 | 16'(v));
        emit(16'h7802);
        emit(16'h7800);
      end
      5: begin
        // STA or STD, word or byte
        v = $urandom % 4;
        emit(16'h8000 | rand_addr(v[0]));
        emit(16'h780c | 16'(v));
      end
      6: begin
        v = $urandom % 2;
        emit(16'h8000 | rand_addr(v[0]));
        emit(16'h7808 | 16'(v));
      end
      default: emit(16'h3000 | 16'($urandom % 4096));
    endcase
  end
  // End marker store
  emit(16'h8000 | 16'($urandom % 32768));
  emit(16'h21ff);
endtask

function automatic logic [15:0] alu_ref(logic [5:0] f, logic [15:0] a, logic [15:0] b);
  case (f)
    6'h00: return a;
    6'h01: return a + 16'd1;
    6'h02: return a + 16'd2;
    6'h04: return ~a;
    6'h0f: return b;
    6'h10: return a & b;
    6'h11: return a | b;
    6'h12: return a ^ b;
    6'h13: return a | {b[7:0], 8'h00};
    6'h14: return a >> b;
    6'h15: return 16'($signed(a) >>> b);
    6'h16: return a << b;
    6'h20: return a + b;
    6'h21: return a - b;
    6'h22: return 16'(a * b);
    6'h28: return {15'd0, $signed(a) < $signed(b)};
    6'h29: return {15'd0, a == b};
    6'h2a: return {15'd0, a != b};
    default: return a;
  endcase
endfunction

task automatic dpush(logic [15:0] v);
  for (int i = 7; i > 0; i--) ds[i] = ds[i-1];
  ds[0] = v;
endtask

task automatic dpop();
  for (int i = 0; i < 7; i++) ds[i] = ds[i+1];
  ds[7] = 16'd0;
endtask

task automatic cpush(logic [15:0] v);
  for (int i = 7; i > 0; i--) cs[i] = cs[i-1];
  cs[0] = v;
endtask

task automatic cpop();
  for (int i = 0; i < 7; i++) cs[i] = cs[i+1];
  cs[7] = 16'd0;
endtask

// Built-in area reads zero, timer has expired by then
function automatic logic [15:0] mread(logic [15:0] addr, bit byt);
  logic [11:0] a;
  logic [15:0] w;
  a = addr[11:0];
  w = (a < 12'h080) ? 16'd0 : {mmem[{a[11:1], 1'b1}], mmem[{a[11:1], 1'b0}]};
  if (!byt) return w;
  return a[0] ? {8'h00, w[15:8]} : {8'h00, w[7:0]};
endfunction

task automatic mwrite(logic [15:0] addr, logic [15:0] data, bit byt);
  logic [11:0] a;
  a = addr[11:0];
  exp_addr.push_back({4'h0, a});
  exp_data.push_back(data);
  exp_byt.push_back(byt);
  if (byt) begin
    mmem[a] = data[7:0];
  end else begin
    mmem[{a[11:1], 1'b0}] = data[7:0];
    mmem[{a[11:1], 1'b1}] = data[15:8];
  end
  if (a == 12'h1fe) model_done = 1'b1;
endtask

task automatic run_model();
  logic [15:0] w;
  logic [15:0] off;
  logic [15:0] base;
  logic [15:0] t;
  bit          c;
  for (int i = 0; i < 4096; i++) mmem[i] = image[i];
  for (int i = 0; i < 8; i++) begin
    ds[i] = 16'd0;
    cs[i] = 16'd0;
  end
  m_ip = `RESET_IP;
  m_fp = 16'd0;
  model_cycles = 0;
  model_done = 1'b0;
  for (int s = 0; s < STEP_LIMIT && !model_done; s++) begin
    w = {mmem[m_ip[11:0] | 12'd1], mmem[m_ip[11:0]]};
    m_ip = m_ip + 16'd2;
    model_cycles += 3;
    // Base register for the X field
    case (w[11:10])
      2'd1: base = m_fp;
      2'd2: base = m_ip;
      2'd3: base = cs[0];
      default: base = 16'd0;
    endcase
    if (w[15]) begin
      dpush({1'b0, w[14:0]});
    end else if (w[15:12] == 4'h0) begin
      off = {{4{w[11]}}, w[11:1], 1'b0};
      if (w[0]) cpush(m_ip);
      m_ip = m_ip + off;
    end else if (w[15:12] == 4'h1) begin
      off = {{4{w[11]}}, w[11:1], 1'b0};
      c = (ds[0] != 16'd0);
      dpop();
      if (w[0] ? c : !c) m_ip = m_ip + off;
    end else if (w[15:12] == 4'h2) begin
      off = {{6{w[9]}}, w[9:1], 1'b0};
      if (w[0]) begin
        mwrite(base + off, ds[0], 1'b0);
        dpop();
      end else begin
        model_cycles += 1;
        dpush(mread(base + off, 1'b0));
      end
    end else if (w[15:12] == 4'h3) begin
      dpush(base + {{6{w[9]}}, w[9:0]});
    end else if (w[15:12] == 4'h4) begin
      m_fp = m_fp + {{6{w[9]}}, w[9:0]};
    end else if (w[15:12] == 4'h7 && !w[11]) begin
      // EXEC is the last of the three cycles just counted
      alu_cyc.push_back(model_cycles - 1);
      alu_code.push_back(w[5:0]);
      t = alu_ref(w[5:0], ds[0], ds[1]);
      if (w[7]) begin
        dpush(t);
      end else begin
        if (w[6]) dpop();
        ds[0] = t;
      end
    end else if (w[15:12] == 4'h7) begin
      case (w[3:0])
        4'h0: begin
          m_ip = cs[0];
          cpop();
        end
        4'h2: begin
          m_fp = cs[0];
          cpop();
        end
        4'h3: cpush(m_fp);
        4'h8, 4'h9: begin
          model_cycles += 1;
          ds[0] = mread(ds[0], w[0]);
        end
        4'hc, 4'hd, 4'he, 4'hf: begin
          // Value below, address on top
          t = ds[0];
          mwrite(ds[0], w[0] ? {ds[1][7:0], ds[1][7:0]} : ds[1], w[0]);
          dpop();
          // STA keeps the address
          if (!w[1]) ds[0] = t;
        end
        default: ;
      endcase
    end
  end
endtask

`endif

// File: verif/tb_cpu.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module tb_cpu;

  logic                   clk;
  logic                   rst;
  logic [15:0]            rd_data = 16'h0000;
  logic [`ADDR_WIDTH-1:0] mem_addr;
  logic                   wr_mem;
  logic                   byt;
  logic [15:0]            wr_data;
  logic [15:0]            stack0;
  logic [15:0]            stack1;
  logic [5:0]             alu_sel;
  // Byte-wide memory behind the CPU
  logic [7:0]             mem [4096];
  int                     cyc;
  bit                     done;

  `include "cpu_model.svh"

  cpu i_cpu (
    .clk      (clk),
    .rst      (rst),
    .rd_data  (rd_data),
    .mem_addr (mem_addr),
    .wr_mem   (wr_mem),
    .byt      (byt),
    .wr_data  (wr_data),
    .stack0   (stack0),
    .stack1   (stack1),
    .alu_sel  (alu_sel)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Program loaded during reset, reads return one cycle later
  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 4096; i++) mem[i] <= image[i];
    end else if (wr_mem) begin
      if (byt) begin
        // Odd byte lives on the high lane
        mem[mem_addr] <= mem_addr[0] ? wr_data[15:8] : wr_data[7:0];
      end else begin
        mem[{mem_addr[11:1], 1'b0}] <= wr_data[7:0];
        mem[{mem_addr[11:1], 1'b1}] <= wr_data[15:8];
      end
    end
    rd_data <= {mem[{mem_addr[11:1], 1'b1}], mem[{mem_addr[11:1], 1'b0}]};
  end

  // Cycle index since reset release
  always @(posedge clk) begin
    if (rst) cyc <= 0;
    else     cyc <= cyc + 1;
  end

  task automatic check_value(string name, logic [15:0] got, logic [15:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
      $display("TB FAILED");
      $fatal(1);
    end
  endtask

  initial begin
    #((STEP_LIMIT * 4 + 300) * 40);
    $display("Timeout: the CPU never reached the end marker store");
    $display("TB FAILED");
    $fatal(1);
  end

  initial begin
    logic [15:0] a;
    logic [15:0] d;
    bit          b;
    void'($urandom(32'h32a8));
    rst = 1'b1;
    done = 1'b0;
    gen_program();
    run_model();
    if (!model_done) begin
      $display("The model never reached the end marker store");
      $display("TB FAILED");
      $fatal(1);
    end
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    // First fetch right after reset, ip advanced by INC2
    @(negedge clk);
    check_value("mem_addr", 16'(mem_addr), `RESET_IP);
    check_value("wr_mem", 16'(wr_mem), 16'h0000);
    check_value("alu_sel", 16'(alu_sel), 16'h0002);
    while (!done) begin
      @(negedge clk);
      // Stack operation in its EXEC cycle shows its own function code
      if (alu_cyc.size() != 0 && cyc == alu_cyc[0]) begin
        alu_cyc.delete(0);
        check_value("alu_sel", 16'(alu_sel), 16'(alu_code.pop_front()));
      end
      if (wr_mem) begin
        if (exp_addr.size() == 0) begin
          $display("The CPU wrote memory after the expected writes ran out");
          $display("TB FAILED");
          $fatal(1);
        end
        a = exp_addr.pop_front();
        d = exp_data.pop_front();
        b = exp_byt.pop_front();
        check_value("mem_addr", 16'(mem_addr), a);
        check_value("byt", 16'(byt), 16'(b));
        // Byte writes carry the byte on both lanes
        check_value("wr_data", wr_data, d);
        if (mem_addr == 12'h1fe) begin
          // 3 cycles per instruction, 4 for loads
          check_value("cycle", 16'(cyc + 1), 16'(model_cycles));
          done = 1'b1;
        end
      end
    end
    // Stacks settle on the edge that ends the store
    @(negedge clk);
    check_value("stack0", stack0, ds[0]);
    check_value("stack1", stack1, ds[1]);
    if (alu_cyc.size() != 0) begin
      $display("Some stack operations were never seen in their EXEC cycle");
      $display("TB FAILED");
      $fatal(1);
    end
    $display("TB PASSED");
    $finish;
  end

endmodule

// File: design/cpu.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu import cpu_isa_pkg::*, cpu_ctrl_pkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [15:0]            rd_data,
  output logic [`ADDR_WIDTH-1:0] mem_addr,
  output logic                   wr_mem,
  output logic                   byt,
  output logic [15:0]            wr_data,
  output logic [15:0]            stack0,
  output logic [15:0]            stack1,
  output logic [5:0]             alu_sel
);

  cpu_ctrl_if ctrl ();

  logic [15:0] fp, ip, insn;
  logic [15:0] src_a, src_b, imm_b, alu_out, stack_in, cstack0;
  logic [15:0] rd_word, rd_fmt, st_word, timer_cnt;
  logic        addr0_d, builtin_d, timer_d;
  logic        load_cdtimer;

  // Operand A select
  always_comb begin
    case (ctrl.src_a)
      FP:      src_a = fp;
      IP:      src_a = ip;
      CSTK:    src_a = cstack0;
      default: src_a = stack0;
    endcase
  end

  // Masked immediate, sign fills the bits above the field
  assign imm_b = (insn & ctrl.imm_mask) |
                 (ctrl.sign ? {~ctrl.imm_mask[15:10], 10'd0} : 16'd0);
  assign src_b = ctrl.imm ? imm_b : stack1;

  // Fetch and branches put ip on the bus, everything else the ALU result
  assign mem_addr = ctrl.load_ip ? ip[`ADDR_WIDTH-1:0] : alu_out[`ADDR_WIDTH-1:0];

  // Built-in area replaces memory data, decoded from the previous address
  assign rd_word = timer_d ? timer_cnt : (builtin_d ? 16'd0 : rd_data);
  // Byte reads zero-extended, odd address takes the high lane
  assign rd_fmt = !ctrl.byt ? rd_word :
                  (addr0_d ? {8'h00, rd_word[15:8]} : {8'h00, rd_word[7:0]});
  assign stack_in = (ctrl.stk_in == STK_IN_MEM) ? rd_fmt : alu_out;

  // Byte writes carry the byte on both lanes
  assign st_word = ctrl.wr_stk1 ? stack1 : stack0;
  assign wr_data = ctrl.byt ? {st_word[7:0], st_word[7:0]} : st_word;
  assign wr_mem  = ctrl.wr_mem;
  assign byt     = ctrl.byt;
  assign alu_sel = ctrl.alu_sel;

  assign load_cdtimer = ctrl.wr_mem && (mem_addr == `ADDR_WIDTH'h002);

  alu i_alu (
    .a    (src_a),
    .b    (src_b),
    .cond (stack0 != 16'd0),
    .sel  (ctrl.alu_sel),
    .out  (alu_out)
  );

  stack #(.DEPTH(`DSTACK_DEPTH)) i_dstack (
    .clk     (clk),
    .rst     (rst),
    .pop     (ctrl.pop),
    .push    (ctrl.push),
    .load    (ctrl.load_stk),
    .data_in (stack_in),
    .data0   (stack0),
    .data1   (stack1)
  );

  // Return address or fp comes straight from operand A
  stack #(.DEPTH(`CSTACK_DEPTH)) i_cstack (
    .clk     (clk),
    .rst     (rst),
    .pop     (ctrl.cpop),
    .push    (ctrl.cpush),
    .load    (ctrl.cpush),
    .data_in (src_a),
    .data0   (cstack0),
    .data1   ()
  );

  insn_decoder i_decoder (
    .clk  (clk),
    .rst  (rst),
    .insn (insn),
    .ctrl (ctrl)
  );

  cdtimer i_cdtimer (
    .clk     (clk),
    .rst     (rst),
    .load    (load_cdtimer),
    .data    (wr_data),
    .counter (timer_cnt),
    .timeout ()
  );

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      fp   <= 16'd0;
      ip   <= `RESET_IP;
      insn <= 16'd0;
    end else begin
      if (ctrl.load_fp)   fp   <= alu_out;
      if (ctrl.load_ip)   ip   <= alu_out;
      if (ctrl.load_insn) insn <= rd_data;
    end
  end

  // Address decode delayed to line up with read data
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      addr0_d   <= 1'b0;
      builtin_d <= 1'b0;
      timer_d   <= 1'b0;
    end else begin
      addr0_d   <= mem_addr[0];
      builtin_d <= (mem_addr[`ADDR_WIDTH-1:7] == '0);
      timer_d   <= (mem_addr[`ADDR_WIDTH-1:1] == 1);
    end
  end

endmodule

// File: design/cdtimer.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module cdtimer (
  input  logic        clk,
  input  logic        rst,
  input  logic        load,
  input  logic [15:0] data,
  output logic [15:0] counter,
  output logic        timeout
);

  localparam int PRESCALE = `CDTIMER_PRESCALE;

  logic [15:0] pre_cnt;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      counter <= 16'd0;
      pre_cnt <= 16'd0;
    end else if (load) begin
      // New count, prescaler restarts
      counter <= data;
      pre_cnt <= 16'd0;
    end else if (counter != 16'd0) begin
      if (pre_cnt == 16'(PRESCALE - 1)) begin
        pre_cnt <= 16'd0;
        counter <= counter - 16'd1;
      end else begin
        pre_cnt <= pre_cnt + 16'd1;
      end
    end
  end

  // Held while expired
  assign timeout = (counter == 16'd0);

endmodule

// File: design/insn_decoder.sv
`timescale 1ns/1ps

module insn_decoder import cpu_isa_pkg::*, cpu_ctrl_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic [15:0]        insn,
  cpu_ctrl_if.decoder        ctrl
);

  phase_e      phase;
  phase_e      phase_next;
  insn_group_e group;
  logic        reserved;
  logic        is_load;

  // Group from the opcode bits, unlisted patterns flagged reserved
  always_comb begin
    group    = OTHER;
    reserved = 1'b0;
    casez (insn[15:12])
      4'b1???: group = PUSH_IMM;
      4'b0000: group = JMP_CALL;
      4'b0001: group = JZ_JNZ;
      4'b0010: group = LD_ST;
      4'b0011: group = PUSH_X;
      4'b0100: begin
        group    = ADD_FP;
        reserved = |insn[11:10];
      end
      4'b0111: begin
        group    = insn[11] ? OTHER : STACK_OP;
        reserved = (|insn[10:8]) | (insn[11] & (|insn[7:4]));
      end
      default: reserved = 1'b1;
    endcase
  end

  // LD and LDD need the extra MEM cycle
  assign is_load = !reserved &&
                   ((group == LD_ST && !insn[0]) ||
                    (group == OTHER && insn[3:1] == 3'b100));

  always_comb begin
    case (phase)
      FETCH:   phase_next = LATCH;
      LATCH:   phase_next = EXEC;
      EXEC:    phase_next = is_load ? MEM : FETCH;
      default: phase_next = FETCH;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) phase <= FETCH;
    else     phase <= phase_next;
  end

  always_comb begin
    // Idle defaults, ALU passes stack top
    ctrl.imm       = 1'b0;
    ctrl.sign      = 1'b0;
    ctrl.imm_mask  = 16'h0000;
    ctrl.src_a     = STK0;
    ctrl.alu_sel   = ALU_PASS_A;
    ctrl.wr_stk1   = 1'b0;
    ctrl.pop       = 1'b0;
    ctrl.push      = 1'b0;
    ctrl.load_stk  = 1'b0;
    ctrl.stk_in    = STK_IN_ALU;
    ctrl.load_fp   = 1'b0;
    ctrl.load_ip   = 1'b0;
    ctrl.load_insn = 1'b0;
    ctrl.cpop      = 1'b0;
    ctrl.cpush     = 1'b0;
    ctrl.byt       = 1'b0;
    ctrl.wr_mem    = 1'b0;
    case (phase)
      FETCH: begin
        // Address out is ip, ip moves to the next word
        ctrl.src_a   = IP;
        ctrl.alu_sel = ALU_INC2;
        ctrl.load_ip = 1'b1;
      end
      LATCH: ctrl.load_insn = 1'b1;
      EXEC: begin
        if (!reserved) begin
          case (group)
            PUSH_IMM: begin
              ctrl.imm      = 1'b1;
              ctrl.imm_mask = 16'h7fff;
              ctrl.alu_sel  = ALU_PASS_B;
              ctrl.push     = 1'b1;
              ctrl.load_stk = 1'b1;
            end
            JMP_CALL, JZ_JNZ: begin
              // 12-bit even offset relative to the advanced ip
              ctrl.imm      = 1'b1;
              ctrl.sign     = insn[11];
              ctrl.imm_mask = 16'h0ffe;
              ctrl.src_a    = IP;
              ctrl.load_ip  = 1'b1;
              if (group == JMP_CALL) begin
                ctrl.alu_sel = ALU_ADDR;
                ctrl.cpush   = insn[0];
              end else begin
                ctrl.alu_sel = insn[0] ? ALU_BR_NZ : ALU_BR_Z;
                ctrl.pop     = 1'b1;
              end
            end
            LD_ST, PUSH_X: begin
              ctrl.imm      = 1'b1;
              ctrl.sign     = insn[9];
              // LD/ST keep bit 0 as the direction flag
              ctrl.imm_mask = (group == LD_ST) ? 16'h03fe : 16'h03ff;
              // Base X, zero base passes the offset alone
              case (insn[11:10])
                2'd1:    ctrl.src_a = FP;
                2'd2:    ctrl.src_a = IP;
                2'd3:    ctrl.src_a = CSTK;
                default: ctrl.src_a = STK0;
              endcase
              ctrl.alu_sel = (insn[11:10] == 2'd0) ? ALU_PASS_B : ALU_ADDR;
              if (group == PUSH_X) begin
                ctrl.push     = 1'b1;
                ctrl.load_stk = 1'b1;
              end else if (insn[0]) begin
                ctrl.wr_mem = 1'b1;
                ctrl.pop    = 1'b1;
              end
            end
            ADD_FP: begin
              ctrl.imm      = 1'b1;
              ctrl.sign     = insn[9];
              ctrl.imm_mask = 16'h03ff;
              ctrl.src_a    = FP;
              ctrl.alu_sel  = ALU_ADDR;
              ctrl.load_fp  = 1'b1;
            end
            STACK_OP: begin
              // Push, Pop and ALU fields straight from the word
              ctrl.alu_sel  = alu_sel_e'(insn[5:0]);
              ctrl.push     = insn[7];
              ctrl.pop      = insn[6];
              ctrl.load_stk = 1'b1;
            end
            default: begin
              case (insn[3:0])
                // RET
                4'b0000: begin
                  ctrl.src_a   = CSTK;
                  ctrl.load_ip = 1'b1;
                  ctrl.cpop    = 1'b1;
                end
                // CPOP FP
                4'b0010: begin
                  ctrl.src_a   = CSTK;
                  ctrl.load_fp = 1'b1;
                  ctrl.cpop    = 1'b1;
                end
                // CPUSH FP
                4'b0011: begin
                  ctrl.src_a = FP;
                  ctrl.cpush = 1'b1;
                end
                // LDD, address is the stack top
                4'b1000, 4'b1001: ctrl.byt = insn[0];
                // STA keeps the address on top
                4'b1100, 4'b1101: begin
                  ctrl.wr_mem   = 1'b1;
                  ctrl.wr_stk1  = 1'b1;
                  ctrl.byt      = insn[0];
                  ctrl.pop      = 1'b1;
                  ctrl.load_stk = 1'b1;
                end
                // STD leaves the value on top
                4'b1110, 4'b1111: begin
                  ctrl.wr_mem  = 1'b1;
                  ctrl.wr_stk1 = 1'b1;
                  ctrl.byt     = insn[0];
                  ctrl.pop     = 1'b1;
                end
                default: ;
              endcase
            end
          endcase
        end
      end
      default: begin
        // Read data onto the stack, LDD replaces its address
        ctrl.stk_in   = STK_IN_MEM;
        ctrl.load_stk = 1'b1;
        ctrl.push     = (group == LD_ST);
        ctrl.byt      = (group == OTHER) & insn[0];
      end
    endcase
  end

endmodule

// File: design/stack.sv
`timescale 1ns/1ps

module stack #(
  parameter int DEPTH = 8
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        pop,
  input  logic        push,
  input  logic        load,
  input  logic [15:0] data_in,
  output logic [15:0] data0,
  output logic [15:0] data1
);

  logic [15:0] entry [DEPTH];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < DEPTH; i++) entry[i] <= 16'd0;
    end else if (push) begin
      // Shift down, new top from data_in when loading
      for (int i = 1; i < DEPTH; i++) entry[i] <= entry[i-1];
      if (load) entry[0] <= data_in;
    end else if (pop) begin
      // Shift up, bottom refills with zero
      for (int i = 0; i < DEPTH - 1; i++) entry[i] <= entry[i+1];
      entry[DEPTH-1] <= 16'd0;
      // Load replaces the new top
      if (load) entry[0] <= data_in;
    end else if (load) begin
      entry[0] <= data_in;
    end
  end

  assign data0 = entry[0];
  assign data1 = entry[1];

endmodule

// File: design/alu.sv
`timescale 1ns/1ps

module alu import cpu_isa_pkg::*; (
  input  logic [15:0] a,
  input  logic [15:0] b,
  input  logic        cond,
  input  alu_sel_e    sel,
  output logic [15:0] out
);

  // Shared adder for ADD and address/branch target forming
  logic [15:0] sum;

  assign sum = a + b;

  always_comb begin
    case (sel)
      ALU_PASS_A: out = a;
      ALU_INC:    out = a + 16'd1;
      ALU_INC2:   out = a + 16'd2;
      ALU_NOT:    out = ~a;
      ALU_PASS_B: out = b;
      ALU_AND:    out = a & b;
      ALU_OR:     out = a | b;
      ALU_XOR:    out = a ^ b;
      // High byte from B, low byte from A
      ALU_JOIN:   out = a | (b << 8);
      ALU_SHR:    out = a >> b;
      ALU_SAR:    out = $signed(a) >>> b;
      ALU_SHL:    out = a << b;
      ALU_ADD:    out = sum;
      ALU_SUB:    out = a - b;
      // Low half of the product
      ALU_MUL:    out = a * b;
      // Signed compare, result 0 or 1
      ALU_LT:     out = {15'd0, $signed(a) < $signed(b)};
      ALU_EQ:     out = {15'd0, a == b};
      ALU_NEQ:    out = {15'd0, a != b};
      ALU_ADDR:   out = sum;
      // cond is high for a nonzero stack top
      ALU_BR_Z:   out = cond ? a : sum;
      ALU_BR_NZ:  out = cond ? sum : a;
      // Unassigned codes leave A unchanged
      default:    out = a;
    endcase
  end

endmodule

// File: design/cpu_ctrl_if.sv
`timescale 1ns/1ps

interface cpu_ctrl_if import cpu_isa_pkg::*, cpu_ctrl_pkg::*; ();
  // Immediate extraction from the instruction word
  logic        imm;
  logic        sign;
  logic [15:0] imm_mask;
  // ALU operand and function
  src_a_e      src_a;
  alu_sel_e    alu_sel;
  // Data stack control
  logic        wr_stk1;
  logic        pop;
  logic        push;
  logic        load_stk;
  stk_in_e     stk_in;
  // Register loads
  logic        load_fp;
  logic        load_ip;
  logic        load_insn;
  // Call stack control
  logic        cpop;
  logic        cpush;
  // Memory access
  logic        byt;
  logic        wr_mem;

  modport decoder (
    output imm, sign, imm_mask, src_a, alu_sel, wr_stk1, pop, push, load_stk,
           stk_in, load_fp, load_ip, load_insn, cpop, cpush, byt, wr_mem
  );

  modport datapath (
    input imm, sign, imm_mask, src_a, alu_sel, wr_stk1, pop, push, load_stk,
          stk_in, load_fp, load_ip, load_insn, cpop, cpush, byt, wr_mem
  );
endinterface

// File: design/cpu_ctrl_pkg.sv
package cpu_ctrl_pkg;

  // Execution phase of one instruction
  //   FETCH  address out, ip advanced
  //   LATCH  instruction word captured
  //   EXEC   instruction completes
  //   MEM    load data pushed
  typedef enum logic [1:0] {
    FETCH = 2'd0,
    LATCH = 2'd1,
    EXEC  = 2'd2,
    MEM   = 2'd3
  } phase_e;

  // Source for the top of the data stack
  typedef enum logic {
    STK_IN_ALU = 1'b0,
    STK_IN_MEM = 1'b1
  } stk_in_e;

endpackage

// File: design/cpu_isa_pkg.sv
package cpu_isa_pkg;

  // Instruction group from the top opcode bits
  typedef enum logic [2:0] {
    PUSH_IMM = 3'd0,
    JMP_CALL = 3'd1,
    JZ_JNZ   = 3'd2,
    LD_ST    = 3'd3,
    PUSH_X   = 3'd4,
    ADD_FP   = 3'd5,
    STACK_OP = 3'd6,
    OTHER    = 3'd7
  } insn_group_e;

  // ALU function codes, low 6 bits of a stack operation
  typedef enum logic [5:0] {
    ALU_PASS_A = 6'h00,
    ALU_INC    = 6'h01,
    ALU_INC2   = 6'h02,
    ALU_NOT    = 6'h04,
    ALU_PASS_B = 6'h0f,
    ALU_AND    = 6'h10,
    ALU_OR     = 6'h11,
    ALU_XOR    = 6'h12,
    ALU_JOIN   = 6'h13,
    ALU_SHR    = 6'h14,
    ALU_SAR    = 6'h15,
    ALU_SHL    = 6'h16,
    ALU_ADD    = 6'h20,
    ALU_SUB    = 6'h21,
    ALU_MUL    = 6'h22,
    ALU_LT     = 6'h28,
    ALU_EQ     = 6'h29,
    ALU_NEQ    = 6'h2a,
    // Internal codes, never taken from an instruction field
    ALU_ADDR   = 6'h30,
    ALU_BR_Z   = 6'h3e,
    ALU_BR_NZ  = 6'h3f
  } alu_sel_e;

  // ALU-A operand source
  typedef enum logic [1:0] {
    STK0 = 2'd0,
    FP   = 2'd1,
    IP   = 2'd2,
    CSTK = 2'd3
  } src_a_e;

endpackage

// File: design/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Memory address width in bits
`define ADDR_WIDTH 12
// First instruction fetched after reset
`define RESET_IP 16'h0300
// Register stack depths
`define DSTACK_DEPTH 8
`define CSTACK_DEPTH 8
// Clocks per countdown timer decrement, small for simulation
`define CDTIMER_PRESCALE 4

`endif
